// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       := uart_tx_tb
FILELIST  := uart_tx_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression passed" $(LOG); then \
		echo "simulation PASS"; \
	else \
		echo "simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== src/uart_baud_gen.sv ====
`default_nettype none

module uart_baud_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic baud_run,
  output logic tick
);
  import uart_cfg_pkg::*;

  localparam logic [baud_cnt_w-1:0] cnt_max = baud_cnt_w'(clks_per_bit - 1);

  logic [baud_cnt_w-1:0] cnt;

  // held at zero when stopped so the first bit is full width.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!baud_run) begin
      cnt <= '0;
    end else if (cnt == cnt_max) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign tick = baud_run && (cnt == cnt_max);

endmodule

`default_nettype wire

// ==== src/uart_cfg_pkg.sv ====
`default_nettype none

package uart_cfg_pkg;

  // system clock and line rate.
  localparam int unsigned clock_freq = 1_000_000;
  localparam int unsigned baud_rate  = 250_000;

  // clocks per serial bit.
  localparam int unsigned clks_per_bit = clock_freq / baud_rate;

  // baud counter needs at least one bit even at a divisor of one.
  localparam int unsigned baud_cnt_w =
    (clks_per_bit > 1) ? $clog2(clks_per_bit) : 1;

  // fifo depth must be a power of two.
  localparam int unsigned fifo_depth  = 4;
  localparam int unsigned fifo_addr_w = $clog2(fifo_depth);

  // frame is fixed at 8-n-1.
  localparam int unsigned data_w    = 8;
  localparam int unsigned bit_idx_w = 3;

endpackage

`default_nettype wire

// ==== src/uart_tx_ctrl.sv ====
`default_nettype none

module uart_tx_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      empty,
  input  logic                      tick,
  input  logic                      data_bit,
  input  logic                      last_bit,
  output logic                      pop,
  output uart_types_pkg::shift_op_t shift_op,
  output logic                      baud_run,
  output logic                      utx_pin,
  output logic                      busy
);
  import uart_types_pkg::*;

  tx_state_t state;
  tx_state_t state_next;
  logic      pin_next;

  always_comb begin
    state_next = state;
    pop        = 1'b0;
    shift_op   = SHIFT_HOLD;
    pin_next   = 1'b1;

    case (state)
      IDLE: begin
        // pop and load together.
        if (!empty) begin
          pop        = 1'b1;
          shift_op   = SHIFT_LOAD;
          state_next = START;
        end
      end

      START: begin
        pin_next = 1'b0;
        if (tick) begin
          state_next = DATA;
        end
      end

      DATA: begin
        pin_next = data_bit;
        if (tick) begin
          if (last_bit) begin
            state_next = STOP;
          end else begin
            shift_op = SHIFT_NEXT;
          end
        end
      end

      STOP: begin
        if (tick) begin
          state_next = IDLE;
        end
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

  assign baud_run = (state != IDLE);
  assign busy     = (state != IDLE);

  // line is registered and trails the state by one cycle.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= IDLE;
      utx_pin <= 1'b1;
    end else begin
      state   <= state_next;
      utx_pin <= pin_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_tx_fifo.sv ====
`default_nettype none

module uart_tx_fifo (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr_en,
  input  logic [uart_cfg_pkg::data_w-1:0] wr_data,
  input  logic                          pop,
  output logic [uart_cfg_pkg::data_w-1:0] rd_data,
  output logic                          full,
  output logic                          empty
);
  import uart_cfg_pkg::*;

  logic [data_w-1:0]      mem [fifo_depth];
  logic [fifo_addr_w-1:0] wr_ptr;
  logic [fifo_addr_w-1:0] rd_ptr;
  logic [fifo_addr_w:0]   count;
  logic                   do_wr;
  logic                   do_rd;

  // writes while full and pops while empty are dropped.
  assign do_wr = wr_en && !full;
  assign do_rd = pop && !empty;

  assign full    = (count == (fifo_addr_w + 1)'(fifo_depth));
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap naturally since depth is a power of two.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_tx_shifter.sv ====
`default_nettype none

module uart_tx_shifter (
  input  logic                            clk,
  input  logic                            rst_n,
  input  uart_types_pkg::shift_op_t       shift_op,
  input  logic [uart_cfg_pkg::data_w-1:0] load_data,
  output logic                            data_bit,
  output logic                            last_bit
);
  import uart_cfg_pkg::*;
  import uart_types_pkg::*;

  localparam logic [bit_idx_w-1:0] idx_last = bit_idx_w'(data_w - 1);

  logic [data_w-1:0]    byte_q;
  logic [bit_idx_w-1:0] idx;

  // payload byte.
  always_ff @(posedge clk) begin
    if (shift_op == SHIFT_LOAD) begin
      byte_q <= load_data;
    end
  end

  // bit index, lsb first.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idx <= '0;
    end else begin
      case (shift_op)
        SHIFT_LOAD: idx <= '0;
        SHIFT_NEXT: idx <= idx + 1'b1;
        default:    idx <= idx;
      endcase
    end
  end

  assign data_bit = byte_q[idx];
  assign last_bit = (idx == idx_last);

endmodule

`default_nettype wire

// ==== src/uart_tx_top.sv ====
`default_nettype none

module uart_tx_top (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            utx_valid,
  input  logic [uart_cfg_pkg::data_w-1:0] utx_data,
  output logic                            utx_ready,
  output logic                            utx_pin,
  output logic                            busy
);
  import uart_cfg_pkg::*;
  import uart_types_pkg::*;

  logic [data_w-1:0] rd_data;
  logic              full;
  logic              empty;
  logic              pop;
  logic              tick;
  logic              baud_run;
  logic              data_bit;
  logic              last_bit;
  shift_op_t         shift_op;

  // full test lives in the fifo.
  assign utx_ready = !full;

  uart_tx_fifo fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_en  (utx_valid),
    .wr_data(utx_data),
    .pop    (pop),
    .rd_data(rd_data),
    .full   (full),
    .empty  (empty)
  );

  uart_tx_ctrl ctrl (
    .clk     (clk),
    .rst_n   (rst_n),
    .empty   (empty),
    .tick    (tick),
    .data_bit(data_bit),
    .last_bit(last_bit),
    .pop     (pop),
    .shift_op(shift_op),
    .baud_run(baud_run),
    .utx_pin (utx_pin),
    .busy    (busy)
  );

  uart_tx_shifter shifter (
    .clk      (clk),
    .rst_n    (rst_n),
    .shift_op (shift_op),
    .load_data(rd_data),
    .data_bit (data_bit),
    .last_bit (last_bit)
  );

  uart_baud_gen baud_gen (
    .clk     (clk),
    .rst_n   (rst_n),
    .baud_run(baud_run),
    .tick    (tick)
  );

endmodule

`default_nettype wire

// ==== src/uart_types_pkg.sv ====
`default_nettype none

package uart_types_pkg;

  // frame controller states.
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_t;

  // command from controller to shifter.
  typedef enum logic [1:0] {
    SHIFT_HOLD,
    SHIFT_LOAD,
    SHIFT_NEXT
  } shift_op_t;

endpackage

`default_nettype wire

// ==== test/uart_tx_tb.sv ====
`default_nettype none

module uart_tx_tb;
  import uart_cfg_pkg::*;

  localparam int unsigned frame_bits   = data_w + 2;
  localparam int unsigned frame_cycles = frame_bits * clks_per_bit;
  localparam int unsigned stall_limit  = 2 * frame_cycles;
  localparam int unsigned start_limit  = 2 * frame_cycles;
  localparam int unsigned drain_limit  = (fifo_depth + 2) * frame_cycles;
  localparam int unsigned burst_len    = 8;
  localparam int unsigned random_count = 200;

  logic              clk;
  logic              rst_n;
  logic              utx_valid;
  logic [data_w-1:0] utx_data;
  logic              utx_ready;
  logic              utx_pin;
  logic              busy;

  // bytes accepted by the DUT and not yet seen on the line.
  logic [data_w-1:0] ref_q[$];
  logic [31:0]       rng;

  uart_tx_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .utx_valid(utx_valid),
    .utx_data (utx_data),
    .utx_ready(utx_ready),
    .utx_pin  (utx_pin),
    .busy     (busy)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // line levels of one frame, start bit in bit 0.
  function automatic logic [frame_bits-1:0] frame_of(input logic [data_w-1:0] value);
    return {1'b1, value, 1'b0};
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_byte(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                              input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s expected %02h got %02h", $time, what, exp, got));
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("mismatch at %0t: %s expected %b got %b", $time, what, exp, got));
    end
  endtask

  // offers one byte and returns at the edge that accepts it.
  task automatic send_byte(input logic [data_w-1:0] value, output int unsigned stalls);
    stalls = 0;
    utx_valid <= 1'b1;
    utx_data  <= value;
    @(posedge clk);
    while (!utx_ready) begin
      stalls++;
      if (stalls > stall_limit) begin
        fail_run("timeout: utx_ready stayed low while a byte was offered");
      end
      @(posedge clk);
    end
    ref_q.push_back(value);
  endtask

  task automatic wait_drain(input string what);
    int unsigned waited;
    waited = 0;
    @(negedge clk);
    while (ref_q.size() != 0 || busy) begin
      waited++;
      if (waited > drain_limit) begin
        fail_run($sformatf("timeout: %s were not all sent on the line", what));
      end
      @(negedge clk);
    end
  endtask

  task automatic check_idle(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      compare_bit(utx_pin, 1'b1, "idle line level");
      compare_bit(busy, 1'b0, "busy while idle");
      compare_bit(utx_ready, 1'b1, "utx_ready while idle");
    end
    @(posedge clk);
  endtask

  // serial decoder, sampling on falling clock edges.
  initial begin : decode_line
    logic [frame_bits-1:0] exp_frame;
    logic [data_w-1:0]     got_byte;
    logic                  bit_level;
    int unsigned           idle_cycles;
    int unsigned           bit_i;
    int unsigned           cyc_i;
    got_byte  = '0;
    bit_level = 1'b1;
    forever begin
      idle_cycles = 0;
      @(negedge clk);
      while (utx_pin !== 1'b0) begin
        if (ref_q.size() == 0) begin
          idle_cycles = 0;
        end else begin
          idle_cycles++;
        end
        if (idle_cycles > start_limit) begin
          fail_run("timeout: no start bit although bytes were waiting");
        end
        @(negedge clk);
      end
      if (ref_q.size() == 0) begin
        fail_run("start bit seen on the line with no byte written");
      end
      exp_frame = frame_of(ref_q[0]);
      for (bit_i = 0; bit_i < frame_bits; bit_i++) begin
        for (cyc_i = 0; cyc_i < clks_per_bit; cyc_i++) begin
          if (bit_i != 0 || cyc_i != 0) begin
            @(negedge clk);
          end
          if (cyc_i == 0) begin
            bit_level = utx_pin;
          end
          if (bit_i == 0 || bit_i == frame_bits - 1) begin
            compare_bit(utx_pin, exp_frame[bit_i], "framing bit level");
          end else begin
            // data bit holds for its whole period.
            compare_bit(utx_pin, bit_level, "data bit level within its period");
          end
          // controller is back in idle for the last cycle of the stop bit.
          if (bit_i * clks_per_bit + cyc_i < frame_cycles - 1) begin
            compare_bit(busy, 1'b1, "busy during frame");
          end
          if (cyc_i == clks_per_bit / 2 && bit_i >= 1 && bit_i <= data_w) begin
            got_byte[bit_i-1] = utx_pin;
          end
        end
      end
      compare_byte(got_byte, exp_frame[data_w:1], "decoded byte");
      void'(ref_q.pop_front());
    end
  end

  initial begin : stimulus
    int unsigned       stalls;
    int unsigned       idx;
    logic [2:0]        gap;
    logic [data_w-1:0] value;
    clk       = 1'b0;
    rst_n     = 1'b0;
    utx_valid = 1'b0;
    utx_data  = '0;
    rng       = 32'h923a;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    check_idle(16);

    // one frame on its own.
    send_byte(8'ha5, stalls);
    utx_valid <= 1'b0;
    wait_drain("single byte");
    check_idle(4);

    // fifo plus the loaded byte go in before ready drops.
    for (idx = 0; idx < burst_len; idx++) begin
      rng = xorshift32(rng);
      send_byte(rng[data_w-1:0], stalls);
      compare_bit(stalls != 0, idx > fifo_depth, "utx_ready low during burst");
    end
    utx_valid <= 1'b0;
    wait_drain("burst bytes");
    check_idle(4);

    for (idx = 0; idx < random_count; idx++) begin
      rng   = xorshift32(rng);
      value = rng[data_w-1:0];
      gap   = rng[18:16];
      send_byte(value, stalls);
      if (gap != 0) begin
        utx_valid <= 1'b0;
        repeat (gap) @(posedge clk);
      end
    end
    utx_valid <= 1'b0;
    wait_drain("random bytes");
    check_idle(8);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_tx_top.f ====
src/uart_cfg_pkg.sv
src/uart_types_pkg.sv
src/uart_baud_gen.sv
src/uart_tx_fifo.sv
src/uart_tx_shifter.sv
src/uart_tx_ctrl.sv
src/uart_tx_top.sv
test/uart_tx_tb.sv
